// File: include/des_consts.svh
`ifndef DES_CONSTS_SVH
`define DES_CONSTS_SVH

// des widths.
`define DES_BLOCK_W   64
`define DES_HALF_W    32
`define DES_SUBKEY_W  48
`define DES_CD_W      28
`define DES_ROUNDS    16

// apb register map, byte offsets.
`define DES_ADDR_KEY_HI     8'h00
`define DES_ADDR_KEY_LO     8'h04
`define DES_ADDR_CIPHER_HI  8'h08
`define DES_ADDR_CIPHER_LO  8'h0C
`define DES_ADDR_CTRL       8'h10
`define DES_ADDR_STATUS     8'h14
`define DES_ADDR_MSG_HI     8'h18
`define DES_ADDR_MSG_LO     8'h1C

`endif

// File: verilog/des_pkg.sv
`include "des_consts.svh"

package des_pkg;

  typedef logic [`DES_BLOCK_W-1:0]  block_t;
  typedef logic [`DES_HALF_W-1:0]   half_t;
  typedef logic [`DES_SUBKEY_W-1:0] subkey_t;
  typedef logic [`DES_CD_W-1:0]     cd_t;
  typedef logic [3:0]               round_t;

  // tables count bits from 1 at the msb.
  localparam byte unsigned IP_TAB [64] = '{
    58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
  };

  localparam byte unsigned E_TAB [48] = '{
    32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9, 8, 9, 10, 11,
    12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
    22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
  };

  localparam byte unsigned P_TAB [32] = '{
    16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
    2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25
  };

  // parity bits 8, 16 .. 64 never appear.
  localparam byte unsigned PC1_TAB [56] = '{
    57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
    10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
    14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4
  };

  localparam byte unsigned PC2_TAB [48] = '{
    14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10, 23, 19, 12, 4,
    26, 8, 16, 7, 27, 20, 13, 2, 41, 52, 31, 37, 47, 55, 30, 40,
    51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
  };

  function automatic block_t perm_ip(input block_t din);
    block_t dout;
    for (int i = 0; i < 64; i++)
      dout[63-i] = din[64-IP_TAB[i]];
    return dout;
  endfunction

  // scatter back through the ip table.
  function automatic block_t perm_ip_inv(input block_t din);
    block_t dout;
    for (int i = 0; i < 64; i++)
      dout[64-IP_TAB[i]] = din[63-i];
    return dout;
  endfunction

  function automatic subkey_t perm_e(input half_t din);
    subkey_t dout;
    for (int i = 0; i < 48; i++)
      dout[47-i] = din[32-E_TAB[i]];
    return dout;
  endfunction

  function automatic half_t perm_p(input half_t din);
    half_t dout;
    for (int i = 0; i < 32; i++)
      dout[31-i] = din[32-P_TAB[i]];
    return dout;
  endfunction

  // returns {c, d}.
  function automatic logic [2*`DES_CD_W-1:0] perm_pc1(input block_t key);
    logic [2*`DES_CD_W-1:0] dout;
    for (int i = 0; i < 56; i++)
      dout[55-i] = key[64-PC1_TAB[i]];
    return dout;
  endfunction

  function automatic subkey_t perm_pc2(input cd_t c, input cd_t d);
    logic [2*`DES_CD_W-1:0] cd;
    subkey_t dout;
    cd = {c, d};
    for (int i = 0; i < 48; i++)
      dout[47-i] = cd[56-PC2_TAB[i]];
    return dout;
  endfunction

endpackage

// File: verilog/des_job_if.sv
interface des_job_if;
  import des_pkg::*;

  block_t key;
  block_t cipher;
  logic   start;   // one cycle, only while idle.
  logic   busy;
  logic   done;    // one cycle, message valid.
  block_t message;

  modport regs (
    output key,
    output cipher,
    output start,
    input  busy,
    input  done,
    input  message
  );

  modport core (
    input  key,
    input  cipher,
    input  start,
    output busy,
    output done,
    output message
  );
endinterface

// File: verilog/des_sbox.sv
`include "des_consts.svh"

module des_sbox (
  input  des_pkg::subkey_t mixed,
  output des_pkg::half_t   substituted
);

  // one entry per box, rows 0..3 from the msb, 16 nibbles a row.
  localparam logic [255:0] SBOX_TAB [8] = '{
    {64'hE4D12FB83A6C5907, 64'h0F74E2D1A6CB9538,
     64'h41E8D62BFC973A50, 64'hFC8249175B3EA06D},
    {64'hF18E6B34972DC05A, 64'h3D47F28EC01A69B5,
     64'h0E7BA4D158C6932F, 64'hD8A13F42B67C05E9},
    {64'hA09E63F51DC7B428, 64'hD70934A6285ECBF1,
     64'hD6498F30B12C5AE7, 64'h1AD069874FE3B52C},
    {64'h7DE3069A1285BC4F, 64'hD8B56F03472C1AE9,
     64'hA690CB7DF13E5284, 64'h3F06A1D8945BC72E},
    {64'h2C417AB6853FD0E9, 64'hEB2C47D150FA3986,
     64'h421BAD78F9C5630E, 64'hB8C71E2D6F09A453},
    {64'hC1AF92680D34E75B, 64'hAF427C9561DE0B38,
     64'h9EF528C3704A1DB6, 64'h432C95FABE17608D},
    {64'h4B2EF08D3C975A61, 64'hD0B7491AE35C2F86,
     64'h14BDC37EAF680592, 64'h6BD814A7950FE23C},
    {64'hD2846FB1A93E50C7, 64'h1FD8A374C56B0E92,
     64'h7B419CE206ADF358, 64'h21E74A8DFC90356B}
  };

  always_comb
  begin
    logic [5:0] grp;
    logic [5:0] idx;
    for (int i = 0; i < 8; i++)
    begin
      grp = mixed[`DES_SUBKEY_W-1-6*i -: 6];
      idx = {grp[5], grp[0], grp[4:1]};  // row from outer bits.
      substituted[`DES_HALF_W-1-4*i -: 4] = SBOX_TAB[i][255-4*idx -: 4];
    end
  end

endmodule

// File: verilog/des_key_schedule.sv
`include "des_consts.svh"

module des_key_schedule (
  input  logic             pclk,
  input  logic             rst_n,
  input  des_pkg::block_t  key,
  input  logic             load,
  input  logic             step,
  output des_pkg::subkey_t subkey
);
  import des_pkg::*;

  cd_t    c_q;
  cd_t    d_q;
  round_t cnt_q;
  logic [2*`DES_CD_W-1:0] cd_init;
  logic   single;

  assign cd_init = perm_pc1(key);

  // after rounds 1, 8 and 15.
  assign single = (cnt_q == 4'd0) || (cnt_q == 4'd7) || (cnt_q == 4'd14);

  // c16/d16 equal c0/d0, so k16 comes out first.
  assign subkey = perm_pc2(c_q, d_q);

  always_ff @(posedge pclk)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else if (load)
      cnt_q <= '0;
    else if (step)
      cnt_q <= cnt_q + 4'd1;
  end

  always_ff @(posedge pclk)
  begin
    if (load)
    begin
      c_q <= cd_init[2*`DES_CD_W-1:`DES_CD_W];
      d_q <= cd_init[`DES_CD_W-1:0];
    end
    else if (step)
    begin
      c_q <= single ? {c_q[0], c_q[`DES_CD_W-1:1]} : {c_q[1:0], c_q[`DES_CD_W-1:2]};
      d_q <= single ? {d_q[0], d_q[`DES_CD_W-1:1]} : {d_q[1:0], d_q[`DES_CD_W-1:2]};
    end
  end

  // the engine never loads mid job.
  a_load_step: assert property (@(posedge pclk) disable iff (!rst_n) !(load && step));

endmodule

// File: verilog/des_round_engine.sv
`include "des_consts.svh"

module des_round_engine (
  input logic     pclk,
  input logic     rst_n,
  des_job_if.core job
);
  import des_pkg::*;

  half_t   l_q;
  half_t   r_q;
  round_t  rnd_q;
  logic    busy_q;
  logic    last;
  subkey_t subkey;
  subkey_t mixed;
  half_t   sbox_out;
  half_t   r_next;
  block_t  ip_out;

  des_key_schedule u_key_schedule (
    .pclk   (pclk),
    .rst_n  (rst_n),
    .key    (job.key),
    .load   (job.start),
    .step   (busy_q),
    .subkey (subkey)
  );

  des_sbox u_sbox (
    .mixed       (mixed),
    .substituted (sbox_out)
  );

  assign ip_out = perm_ip(job.cipher);
  assign mixed  = perm_e(r_q) ^ subkey;
  assign r_next = l_q ^ perm_p(sbox_out);
  assign last   = busy_q && (rnd_q == round_t'(`DES_ROUNDS - 1));

  always_ff @(posedge pclk)
  begin
    if (!rst_n)
    begin
      busy_q <= 1'b0;
      rnd_q  <= '0;
    end
    else if (job.start)
    begin
      busy_q <= 1'b1;
      rnd_q  <= '0;
    end
    else if (busy_q)
    begin
      rnd_q <= rnd_q + 4'd1;  // wraps to 0 after round 16.
      if (last)
        busy_q <= 1'b0;
    end
  end

  always_ff @(posedge pclk)
  begin
    if (job.start)
      {l_q, r_q} <= ip_out;
    else if (busy_q)
    begin
      l_q <= r_q;
      r_q <= r_next;
    end
  end

  // round 16 result goes straight out, halves swapped.
  assign job.busy    = busy_q;
  assign job.done    = last;
  assign job.message = perm_ip_inv({r_next, r_q});

  a_start_idle: assert property (@(posedge pclk) disable iff (!rst_n)
    job.start |-> !busy_q);

  // sixteen busy cycles, the counter never runs past 15.
  a_busy_len: assert property (@(posedge pclk) disable iff (!rst_n)
    $rose(busy_q) |-> busy_q [*16] ##1 !busy_q);

endmodule

// File: verilog/des_apb_regs.sv
`include "des_consts.svh"

module des_apb_regs (
  input  logic        pclk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  des_job_if.regs     job
);
  import des_pkg::*;

  block_t key_q;
  block_t cipher_q;
  block_t msg_q;
  logic   start_q;
  logic   done_q;
  logic   access;
  logic   busy_any;
  logic   mapped;
  logic   writable;
  logic   wr_ok;

  assign access   = psel && penable;
  assign busy_any = job.busy || start_q;  // busy from the cycle after the start write.
  assign pready   = 1'b1;

  always_comb
  begin
    mapped = 1'b1;
    prdata = '0;
    case (paddr)
      `DES_ADDR_KEY_HI:    prdata = key_q[63:32];
      `DES_ADDR_KEY_LO:    prdata = key_q[31:0];
      `DES_ADDR_CIPHER_HI: prdata = cipher_q[63:32];
      `DES_ADDR_CIPHER_LO: prdata = cipher_q[31:0];
      `DES_ADDR_CTRL:      prdata = '0;  // reads as 0.
      `DES_ADDR_STATUS:    prdata = {30'd0, done_q, busy_any};
      `DES_ADDR_MSG_HI:    prdata = msg_q[63:32];
      `DES_ADDR_MSG_LO:    prdata = msg_q[31:0];
      default:             mapped = 1'b0;
    endcase
  end

  // only key, cipher and ctrl take writes.
  assign writable = (paddr == `DES_ADDR_KEY_HI) || (paddr == `DES_ADDR_KEY_LO) ||
                    (paddr == `DES_ADDR_CIPHER_HI) || (paddr == `DES_ADDR_CIPHER_LO) ||
                    (paddr == `DES_ADDR_CTRL);

  assign pslverr = access && (!mapped || (pwrite && (!writable || busy_any)));
  assign wr_ok   = access && pwrite && !pslverr;

  always_ff @(posedge pclk)
  begin
    if (!rst_n)
    begin
      key_q    <= '0;
      cipher_q <= '0;
      msg_q    <= '0;
      start_q  <= 1'b0;
      done_q   <= 1'b0;
    end
    else
    begin
      start_q <= 1'b0;
      if (job.done)
      begin
        msg_q  <= job.message;
        done_q <= 1'b1;
      end
      if (wr_ok)
      begin
        case (paddr)
          `DES_ADDR_KEY_HI:    key_q[63:32]    <= pwdata;
          `DES_ADDR_KEY_LO:    key_q[31:0]     <= pwdata;
          `DES_ADDR_CIPHER_HI: cipher_q[63:32] <= pwdata;
          `DES_ADDR_CIPHER_LO: cipher_q[31:0]  <= pwdata;
          `DES_ADDR_CTRL:
            if (pwdata[0])
            begin
              start_q <= 1'b1;
              done_q  <= 1'b0;
            end
          default: ;
        endcase
      end
    end
  end

  assign job.key    = key_q;
  assign job.cipher = cipher_q;
  assign job.start  = start_q;

  a_err_access: assert property (@(posedge pclk) disable iff (!rst_n)
    pslverr |-> psel && penable);

endmodule

// File: verilog/des_decrypt_top.sv
module des_decrypt_top (
  input  logic        pclk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  des_job_if job ();

  des_apb_regs u_apb_regs (
    .pclk    (pclk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .job     (job.regs)
  );

  // one round per clock.
  des_round_engine u_round_engine (
    .pclk  (pclk),
    .rst_n (rst_n),
    .job   (job.core)
  );

endmodule

// File: tb/des_tb_clk.sv
module des_tb_clk (
  output logic pclk,
  output logic rst_n
);

  initial
  begin
    pclk = 1'b0;
    forever #4 pclk = ~pclk;  // period 8.
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (4) @(posedge pclk);
    #1 rst_n = 1'b1;
  end

endmodule

// File: tb/des_decrypt_tb.sv
`include "des_consts.svh"

module des_decrypt_tb;

  localparam byte unsigned IP_T [64] = '{
    58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
  };
  localparam byte unsigned P_T [32] = '{
    16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
    2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25
  };
  localparam byte unsigned PC1_T [56] = '{
    57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
    10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
    14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4
  };
  localparam byte unsigned PC2_T [48] = '{
    14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10, 23, 19, 12, 4,
    26, 8, 16, 7, 27, 20, 13, 2, 41, 52, 31, 37, 47, 55, 30, 40,
    51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
  };
  // s1 to s8 as four rows of sixteen nibbles.
  localparam logic [255:0] SB [8] = '{
    256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
    256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
    256'hA09E63F51DC7B428_D70934A6285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
    256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
    256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
    256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
    256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
    256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B
  };

  logic        pclk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  integer      seed = 32'hb7abe292;
  logic [63:0] exp_q [$];
  logic [63:0] got_q [$];

  des_tb_clk u_clk (.pclk (pclk), .rst_n (rst_n));

  des_decrypt_top UUT (
    .pclk    (pclk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always @(posedge pclk) cycles <= cycles + 1;

  // keys k1 .. k16 by left rotations, applied last first.
  function automatic logic [63:0] des_decrypt_ref(input logic [63:0] key,
                                                  input logic [63:0] cipher);
    logic [55:0] cd;
    logic [47:0] ks [16];
    logic [63:0] blk;
    logic [63:0] msg;
    logic [31:0] l;
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] f;
    logic [47:0] x;
    logic [5:0]  g;
    for (int i = 0; i < 56; i++)
      cd[55-i] = key[64-PC1_T[i]];
    for (int n = 0; n < 16; n++)
    begin
      for (int k = 0; k < ((n < 2 || n == 8 || n == 15) ? 1 : 2); k++)
        cd = {cd[54:28], cd[55], cd[26:0], cd[27]};
      for (int i = 0; i < 48; i++)
        ks[n][47-i] = cd[56-PC2_T[i]];
    end
    for (int i = 0; i < 64; i++)
      blk[63-i] = cipher[64-IP_T[i]];
    l = blk[63:32];
    r = blk[31:0];
    for (int n = 15; n >= 0; n--)
    begin
      for (int i = 0; i < 48; i++)
        x[47-i] = r[31-(4*(i/6)+i%6+31)%32];  // expansion takes 4 bits to 6.
      x = x ^ ks[n];
      for (int b = 0; b < 8; b++)
      begin
        g = x[47-6*b -: 6];
        s[31-4*b -: 4] = SB[b][255-4*(32*g[5]+16*g[0]+g[4:1]) -: 4];
      end
      for (int i = 0; i < 32; i++)
        f[31-i] = s[32-P_T[i]];
      {l, r} = {r, l ^ f};
    end
    blk = {r, l};
    for (int i = 0; i < 64; i++)
      msg[64-IP_T[i]] = blk[63-i];  // final permutation undoes ip.
    return msg;
  endfunction

  task automatic check_err(input logic [7:0] addr, input logic exp_err);
    checks++;
    assert (pslverr === exp_err)
    else
    begin
      errors++;
      $display("[ERROR] %0t: pslverr %b at offset %h, expected %b", $time, pslverr, addr,
               exp_err);
    end
    checks++;
    assert (pready === 1'b1)
    else
    begin
      errors++;
      $display("[ERROR] %0t: pready %b at offset %h, expected 1", $time, pready, addr);
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    @(posedge pclk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge pclk);
    #1;
    penable = 1'b1;
    #3;
    check_err(addr, exp_err);
    @(posedge pclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, input logic exp_err, output logic [31:0] data);
    @(posedge pclk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge pclk);
    #1;
    penable = 1'b1;
    #3;  // mid access phase.
    data = prdata;
    check_err(addr, exp_err);
    assert (!$isunknown(prdata))
    else
    begin
      errors++;
      $display("read of offset %h returned unknown bits", addr);
    end
    @(posedge pclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic expect_reg(input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    read_reg(addr, 1'b0, data);
    checks++;
    assert (data === exp)
    else
    begin
      errors++;
      $display("[ERROR] %0t: offset %h read %h, expected %h", $time, addr, data, exp);
    end
  endtask

  task automatic wait_done(input int job_id, output logic [31:0] status);
    int start_cycle;
    start_cycle = cycles;
    status = '0;
    while (status[1] !== 1'b1 && cycles - start_cycle < 200)
      read_reg(`DES_ADDR_STATUS, 1'b0, status);
    if (status[1] !== 1'b1)
    begin
      $display("job %0d never finished, done not set within 200 cycles", job_id);
      $display("checks %0d, errors %0d", checks, errors + 1);
      $display("STATUS: FAIL");
      $finish;
    end
  endtask

  task automatic load_job(input logic [63:0] key, input logic [63:0] cipher);
    write_reg(`DES_ADDR_KEY_HI, key[63:32], 1'b0);
    write_reg(`DES_ADDR_KEY_LO, key[31:0], 1'b0);
    write_reg(`DES_ADDR_CIPHER_HI, cipher[63:32], 1'b0);
    write_reg(`DES_ADDR_CIPHER_LO, cipher[31:0], 1'b0);
    write_reg(`DES_ADDR_CTRL, 32'h1, 1'b0);
  endtask

  task automatic finish_job(input int job_id, input logic [63:0] exp);
    logic [31:0] status;
    logic [31:0] hi;
    logic [31:0] lo;
    wait_done(job_id, status);
    read_reg(`DES_ADDR_MSG_HI, 1'b0, hi);
    read_reg(`DES_ADDR_MSG_LO, 1'b0, lo);
    exp_q.push_back(exp);
    got_q.push_back({hi, lo});
  endtask

  always @(posedge pclk)
  begin : compare
    logic [63:0] exp_msg;
    logic [63:0] got_msg;
    if (got_q.size() > 0)
    begin
      exp_msg = exp_q.pop_front();
      got_msg = got_q.pop_front();
      checks++;
      assert (got_msg === exp_msg)
      else
      begin
        errors++;
        $display("[ERROR] %0t: message %h, expected %h", $time, got_msg, exp_msg);
      end
    end
  end

  initial
  begin
    logic [63:0] key;
    logic [63:0] cipher;
    logic [31:0] data;
    int          wait_n;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    wait_n  = 0;
    while (rst_n !== 1'b1 && wait_n < 20)
    begin
      @(posedge pclk);
      wait_n++;
    end
    if (rst_n !== 1'b1)
    begin
      errors++;
      $display("reset was never released");
    end

    expect_reg(`DES_ADDR_STATUS, 32'h0);
    expect_reg(`DES_ADDR_MSG_HI, 32'h0);
    expect_reg(`DES_ADDR_MSG_LO, 32'h0);

    // known vector with operands read back while the job runs.
    key    = 64'h133457799BBCDFF1;
    cipher = 64'h85E813540F0AB405;
    load_job(key, cipher);
    expect_reg(`DES_ADDR_KEY_HI, key[63:32]);
    expect_reg(`DES_ADDR_KEY_LO, key[31:0]);
    expect_reg(`DES_ADDR_CIPHER_HI, cipher[63:32]);
    expect_reg(`DES_ADDR_CIPHER_LO, cipher[31:0]);
    expect_reg(`DES_ADDR_CTRL, 32'h0);
    finish_job(1, 64'h0123456789ABCDEF);
    expect_reg(`DES_ADDR_STATUS, 32'h2);  // busy 0, done 1.

    read_reg(8'h20, 1'b1, data);
    write_reg(`DES_ADDR_STATUS, 32'h3, 1'b1);
    write_reg(`DES_ADDR_MSG_LO, 32'hFFFF_FFFF, 1'b1);

    // each job again with the parity bits flipped.
    for (int j = 0; j < 40; j++)
    begin
      key    = {$random(seed), $random(seed)};
      cipher = {$random(seed), $random(seed)};
      load_job(key, cipher);
      finish_job(2 + 2 * j, des_decrypt_ref(key, cipher));
      load_job(key ^ 64'h0101_0101_0101_0101, cipher);
      finish_job(3 + 2 * j, des_decrypt_ref(key, cipher));
    end

    // operands locked while busy.
    key    = {$random(seed), $random(seed)};
    cipher = {$random(seed), $random(seed)};
    load_job(key, cipher);
    write_reg(`DES_ADDR_KEY_HI, ~key[63:32], 1'b1);
    write_reg(`DES_ADDR_CIPHER_LO, ~cipher[31:0], 1'b1);
    write_reg(`DES_ADDR_CTRL, 32'h1, 1'b1);
    finish_job(100, des_decrypt_ref(key, cipher));
    expect_reg(`DES_ADDR_KEY_HI, key[63:32]);

    wait_n = 0;
    while (got_q.size() > 0 && wait_n < 10)
    begin
      @(posedge pclk);
      wait_n++;
    end
    if (got_q.size() > 0)
    begin
      errors++;
      $display("%0d messages were never compared", got_q.size());
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: sim.f
+incdir+include
verilog/des_pkg.sv
verilog/des_job_if.sv
verilog/des_sbox.sv
verilog/des_key_schedule.sv
verilog/des_round_engine.sv
verilog/des_apb_regs.sv
verilog/des_decrypt_top.sv
tb/des_tb_clk.sv
tb/des_decrypt_tb.sv

// File: Bender.yml
package:
  name: des_decrypt

sources:
  - include_dirs:
      - include
    files:
      - verilog/des_pkg.sv
      - verilog/des_job_if.sv
      - verilog/des_sbox.sv
      - verilog/des_key_schedule.sv
      - verilog/des_round_engine.sv
      - verilog/des_apb_regs.sv
      - verilog/des_decrypt_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/des_tb_clk.sv
      - tb/des_decrypt_tb.sv
